/* irq_pkg.sv */
package irq_pkg;

    // bus and datapath widths
    localparam int XLEN     = 32;
    localparam int TIME_W   = 64;
    localparam int PRIO_W   = 3;
    localparam int SRC_ID_W = 6;

    typedef logic [XLEN-1:0]     paddr_t;
    typedef logic [XLEN-1:0]     pdata_t;
    typedef logic [XLEN/8-1:0]   pstrb_t;
    typedef logic [TIME_W-1:0]   systime_t;
    typedef logic [PRIO_W-1:0]   prio_t;
    // id 0 is reserved for "no source"
    typedef logic [SRC_ID_W-1:0] src_id_t;

    typedef struct packed {
        logic   psel;
        logic   penable;
        paddr_t paddr;
        logic   pwrite;
        pstrb_t pstrb;
        pdata_t pwdata;
    } apb_req_t;

    typedef struct packed {
        pdata_t prdata;
        logic   pready;
        logic   pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic  eligible;
        prio_t prio;
    } irq_gw_t;

    // register map, byte offsets
    localparam paddr_t REG_MSIP        = 32'h0000_0000;
    localparam paddr_t REG_MTIMECMP_LO = 32'h0000_0008;
    localparam paddr_t REG_MTIMECMP_HI = 32'h0000_000C;
    localparam paddr_t REG_MTIME_LO    = 32'h0000_0010;
    localparam paddr_t REG_MTIME_HI    = 32'h0000_0014;
    localparam paddr_t REG_PRIO_BASE   = 32'h0000_0100;
    localparam paddr_t REG_ENABLE      = 32'h0000_0200;
    localparam paddr_t REG_THRESHOLD   = 32'h0000_0204;
    localparam paddr_t REG_CLAIM       = 32'h0000_0208;
    localparam paddr_t REG_PENDING     = 32'h0000_020C;

    // bit positions in the timer write strobe vector
    localparam int TWE_MSIP   = 0;
    localparam int TWE_CMP_LO = 1;
    localparam int TWE_CMP_HI = 2;

    // expand byte strobes to a bit mask
    function automatic pdata_t byte_mask(pstrb_t strb);
        pdata_t m;
        for (int b = 0; b < XLEN/8; b++) begin
            m[b*8 +: 8] = {8{strb[b]}};
        end
        return m;
    endfunction

endpackage

/* irq_gateway.sv */
module irq_gateway (
    input  logic             clk,
    input  logic             arst_n,

    input  logic             src,
    input  logic             prio_we,
    input  irq_pkg::pdata_t  wdata,
    input  irq_pkg::pstrb_t  wstrb,
    input  logic             enable,
    input  logic             claim,
    input  logic             complete,

    output irq_pkg::prio_t   prio,
    output logic             pending,
    output irq_pkg::irq_gw_t stat
);
    import irq_pkg::*;

    logic   in_flight;
    pdata_t wmask;

    assign wmask = byte_mask(wstrb);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prio      <= '0;
            pending   <= 1'b0;
            in_flight <= 1'b0;
        end else begin
            if (prio_we) begin
                prio <= (prio & ~wmask[PRIO_W-1:0]) | (wdata[PRIO_W-1:0] & wmask[PRIO_W-1:0]);
            end

            // level line latched while no request is being serviced
            // complete reopens the gateway in the same cycle
            if (claim) begin
                pending <= 1'b0;
            end else if (src && (!in_flight || complete)) begin
                pending <= 1'b1;
            end

            if (claim) begin
                in_flight <= 1'b1;
            end else if (complete) begin
                in_flight <= 1'b0;
            end
        end
    end

    assign stat.eligible = pending & enable & (|prio);
    assign stat.prio     = prio;

endmodule

/* irq_claim_arb.sv */
module irq_claim_arb #(
    parameter int NUM_SRC = 3
) (
    input  logic             clk,
    input  logic             arst_n,

    input  irq_pkg::irq_gw_t gw_stat [NUM_SRC],
    input  irq_pkg::prio_t   threshold,

    output irq_pkg::src_id_t best_id,
    output logic             meip
);
    import irq_pkg::*;

    prio_t   best_prio;
    src_id_t best;

    // start from the threshold so the winner must beat it
    // strict compare in id order keeps the lowest id on a tie
    always_comb begin
        best_prio = threshold;
        best      = '0;
        for (int i = 0; i < NUM_SRC; i++) begin
            if (gw_stat[i].eligible && (gw_stat[i].prio > best_prio)) begin
                best_prio = gw_stat[i].prio;
                best      = src_id_t'(i + 1);
            end
        end
    end

    assign best_id = best;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            meip <= 1'b0;
        end else begin
            meip <= |best;
        end
    end

endmodule

/* clint_timer.sv */
module clint_timer (
    input  logic              clk,
    input  logic              clk_32k,
    input  logic              arst_n,

    input  logic [2:0]        timer_we,
    input  irq_pkg::pdata_t   wdata,
    input  irq_pkg::pstrb_t   wstrb,

    output irq_pkg::systime_t mtime,
    output irq_pkg::systime_t mtimecmp,
    output logic              msip,
    output logic              mtip
);
    import irq_pkg::*;

    systime_t cnt_bin;
    systime_t cnt_next;
    systime_t cnt_gray;
    systime_t gray_s1;
    systime_t gray_s2;
    pdata_t   wmask;

    function automatic systime_t bin2gray(systime_t b);
        return b ^ (b >> 1);
    endfunction

    function automatic systime_t gray2bin(systime_t g);
        systime_t b;
        b[TIME_W-1] = g[TIME_W-1];
        for (int i = TIME_W - 2; i >= 0; i--) begin
            b[i] = b[i+1] ^ g[i];
        end
        return b;
    endfunction

    assign cnt_next = cnt_bin + systime_t'(1);

    // free running count in the 32 kHz domain
    // gray copy is registered so it never glitches
    always_ff @(posedge clk_32k or negedge arst_n) begin
        if (!arst_n) begin
            cnt_bin  <= '0;
            cnt_gray <= '0;
        end else begin
            cnt_bin  <= cnt_next;
            cnt_gray <= bin2gray(cnt_next);
        end
    end

    // two flop sync, then back to binary
    // only one bit moves per step, so either capture is a valid time
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            gray_s1 <= '0;
            gray_s2 <= '0;
            mtime   <= '0;
        end else begin
            gray_s1 <= cnt_gray;
            gray_s2 <= gray_s1;
            mtime   <= gray2bin(gray_s2);
        end
    end

    assign wmask = byte_mask(wstrb);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            msip     <= 1'b0;
            mtimecmp <= '1;
            mtip     <= 1'b0;
        end else begin
            if (timer_we[TWE_MSIP] && wmask[0]) begin
                msip <= wdata[0];
            end
            if (timer_we[TWE_CMP_LO]) begin
                mtimecmp[XLEN-1:0] <= (mtimecmp[XLEN-1:0] & ~wmask) | (wdata & wmask);
            end
            if (timer_we[TWE_CMP_HI]) begin
                mtimecmp[TIME_W-1:XLEN] <= (mtimecmp[TIME_W-1:XLEN] & ~wmask)
                                         | (wdata & wmask);
            end
            // level, held while time is at or past the compare value
            mtip <= (mtime >= mtimecmp);
        end
    end

endmodule

/* irq_apb_regs.sv */
module irq_apb_regs #(
    parameter int NUM_SRC = 3
) (
    input  logic                clk,
    input  logic                arst_n,

    input  irq_pkg::apb_req_t   apb_req,
    output irq_pkg::apb_rsp_t   apb_rsp,

    input  irq_pkg::systime_t   mtime,
    input  irq_pkg::systime_t   mtimecmp,
    input  logic                msip,
    input  irq_pkg::prio_t      gw_prio [NUM_SRC],
    input  logic [NUM_SRC-1:0]  pending,
    input  irq_pkg::src_id_t    best_id,

    output logic [2:0]          timer_we,
    output irq_pkg::pdata_t     wdata,
    output irq_pkg::pstrb_t     wstrb,
    output logic [NUM_SRC-1:0]  prio_we,
    output logic [NUM_SRC-1:0]  irq_en,
    output logic [NUM_SRC-1:0]  claim,
    output logic [NUM_SRC-1:0]  complete,
    output irq_pkg::prio_t      threshold
);
    import irq_pkg::*;

    logic               access;
    logic               mapped;
    logic               read_only;
    logic               err;
    logic               wr_ok;
    logic               rd_ok;
    logic [NUM_SRC-1:0] prio_sel;
    pdata_t             rdata;
    pdata_t             wmask;

    // access phase of a transfer, always completes in one cycle
    assign access = apb_req.psel & apb_req.penable;
    assign wmask  = byte_mask(apb_req.pstrb);

    always_comb begin
        for (int i = 0; i < NUM_SRC; i++) begin
            prio_sel[i] = (apb_req.paddr == REG_PRIO_BASE + paddr_t'(4 * i));
        end
    end

    // read mux and map check
    always_comb begin
        rdata     = '0;
        mapped    = 1'b1;
        read_only = 1'b0;
        case (apb_req.paddr)
            REG_MSIP:        rdata = pdata_t'(msip);
            REG_MTIMECMP_LO: rdata = mtimecmp[XLEN-1:0];
            REG_MTIMECMP_HI: rdata = mtimecmp[TIME_W-1:XLEN];
            REG_MTIME_LO: begin
                rdata     = mtime[XLEN-1:0];
                read_only = 1'b1;
            end
            REG_MTIME_HI: begin
                rdata     = mtime[TIME_W-1:XLEN];
                read_only = 1'b1;
            end
            REG_ENABLE:      rdata = pdata_t'(irq_en);
            REG_THRESHOLD:   rdata = pdata_t'(threshold);
            REG_CLAIM:       rdata = pdata_t'(best_id);
            REG_PENDING: begin
                rdata     = pdata_t'(pending);
                read_only = 1'b1;
            end
            default: begin
                mapped = |prio_sel;
                for (int i = 0; i < NUM_SRC; i++) begin
                    if (prio_sel[i]) begin
                        rdata = pdata_t'(gw_prio[i]);
                    end
                end
            end
        endcase
    end

    assign err   = ~mapped | (apb_req.pwrite & read_only);
    assign wr_ok = access & apb_req.pwrite & ~err;
    assign rd_ok = access & ~apb_req.pwrite & ~err;

    assign apb_rsp.prdata  = rdata;
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = access & err;

    // strobes toward the timer and the gateways
    assign timer_we[TWE_MSIP]   = wr_ok & (apb_req.paddr == REG_MSIP);
    assign timer_we[TWE_CMP_LO] = wr_ok & (apb_req.paddr == REG_MTIMECMP_LO);
    assign timer_we[TWE_CMP_HI] = wr_ok & (apb_req.paddr == REG_MTIMECMP_HI);
    assign wdata   = apb_req.pwdata;
    assign wstrb   = apb_req.pstrb;
    assign prio_we = {NUM_SRC{wr_ok}} & prio_sel;

    // claim on read of the winner, complete on write of an id
    always_comb begin
        for (int i = 0; i < NUM_SRC; i++) begin
            claim[i]    = rd_ok && (apb_req.paddr == REG_CLAIM)
                          && (best_id == src_id_t'(i + 1));
            complete[i] = wr_ok && (apb_req.paddr == REG_CLAIM) && apb_req.pstrb[0]
                          && (apb_req.pwdata[SRC_ID_W-1:0] == src_id_t'(i + 1));
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            irq_en    <= '0;
            threshold <= '0;
        end else if (wr_ok) begin
            if (apb_req.paddr == REG_ENABLE) begin
                irq_en <= (irq_en & ~wmask[NUM_SRC-1:0])
                        | (apb_req.pwdata[NUM_SRC-1:0] & wmask[NUM_SRC-1:0]);
            end
            if (apb_req.paddr == REG_THRESHOLD) begin
                threshold <= (threshold & ~wmask[PRIO_W-1:0])
                           | (apb_req.pwdata[PRIO_W-1:0] & wmask[PRIO_W-1:0]);
            end
        end
    end

endmodule

/* cpu_irq_subsys.sv */
module cpu_irq_subsys #(
    parameter int NUM_SRC = 3
) (
    input  logic              clk,
    input  logic              clk_32k,
    input  logic              arst_n,

    input  irq_pkg::apb_req_t apb_req,
    output irq_pkg::apb_rsp_t apb_rsp,

    input  logic [NUM_SRC-1:0] irq_src,

    output logic              msip,
    output logic              mtip,
    output logic              meip
);
    import irq_pkg::*;

    logic [2:0]         timer_we;
    pdata_t             wdata;
    pstrb_t             wstrb;
    systime_t           mtime;
    systime_t           mtimecmp;

    logic [NUM_SRC-1:0] prio_we;
    logic [NUM_SRC-1:0] irq_en;
    logic [NUM_SRC-1:0] claim;
    logic [NUM_SRC-1:0] complete;
    logic [NUM_SRC-1:0] pending;
    prio_t              gw_prio [NUM_SRC];
    irq_gw_t            gw_stat [NUM_SRC];
    prio_t              threshold;
    src_id_t            best_id;

    irq_apb_regs #(
        .NUM_SRC ( NUM_SRC )
    ) u_irq_apb_regs (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .apb_req   ( apb_req   ),
        .apb_rsp   ( apb_rsp   ),
        .mtime     ( mtime     ),
        .mtimecmp  ( mtimecmp  ),
        .msip      ( msip      ),
        .gw_prio   ( gw_prio   ),
        .pending   ( pending   ),
        .best_id   ( best_id   ),
        .timer_we  ( timer_we  ),
        .wdata     ( wdata     ),
        .wstrb     ( wstrb     ),
        .prio_we   ( prio_we   ),
        .irq_en    ( irq_en    ),
        .claim     ( claim     ),
        .complete  ( complete  ),
        .threshold ( threshold )
    );

    clint_timer u_clint_timer (
        .clk      ( clk      ),
        .clk_32k  ( clk_32k  ),
        .arst_n   ( arst_n   ),
        .timer_we ( timer_we ),
        .wdata    ( wdata    ),
        .wstrb    ( wstrb    ),
        .mtime    ( mtime    ),
        .mtimecmp ( mtimecmp ),
        .msip     ( msip     ),
        .mtip     ( mtip     )
    );

    // one gateway per peripheral line, source i+1 on line i
    for (genvar i = 0; i < NUM_SRC; i++) begin : g_gw
        irq_gateway u_irq_gateway (
            .clk      ( clk         ),
            .arst_n   ( arst_n      ),
            .src      ( irq_src[i]  ),
            .prio_we  ( prio_we[i]  ),
            .wdata    ( wdata       ),
            .wstrb    ( wstrb       ),
            .enable   ( irq_en[i]   ),
            .claim    ( claim[i]    ),
            .complete ( complete[i] ),
            .prio     ( gw_prio[i]  ),
            .pending  ( pending[i]  ),
            .stat     ( gw_stat[i]  )
        );
    end

    irq_claim_arb #(
        .NUM_SRC ( NUM_SRC )
    ) u_irq_claim_arb (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .gw_stat   ( gw_stat   ),
        .threshold ( threshold ),
        .best_id   ( best_id   ),
        .meip      ( meip      )
    );

endmodule

/* cpu_irq_subsys_tb.sv */
module cpu_irq_subsys_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import irq_pkg::*;

    localparam int          NUM_SRC     = 3;
    localparam int          APB_TIMEOUT = 16;
    localparam int          PIN_MEIP    = 0;
    localparam int          PIN_MTIP    = 1;
    localparam int          PIN_MSIP    = 2;
    localparam logic [31:0] LFSR_SEED   = 32'd97677;
    localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;
    localparam pdata_t      ALL_SRC     = pdata_t'((1 << NUM_SRC) - 1);

    typedef logic [63:0] val_t;

    // for writes the expected field holds pslverr
    // for pin waits the offset picks the pin and data holds the cycle limit
    typedef enum {OP_WR, OP_RD, OP_RDERR, OP_IRQ, OP_PIN, OP_TIME} op_e;

    typedef struct {
        op_e    op;
        paddr_t offset;
        pdata_t data;
        pdata_t expected;
    } row_t;

    logic               clk;
    logic               clk_32k;
    logic               arst_n;
    apb_req_t           apb_req;
    apb_rsp_t           apb_rsp;
    logic [NUM_SRC-1:0] irq_src;
    logic               msip;
    logic               mtip;
    logic               meip;

    row_t        table_q [$];
    prio_t       prio_m [NUM_SRC];
    logic [31:0] lfsr;
    systime_t    last_time;
    logic        time_seen;
    int          checks;
    int          mismatches;
    int          timeouts;
    string       pin_names [3] = '{"meip", "mtip", "msip"};

    cpu_irq_subsys #(
        .NUM_SRC ( NUM_SRC )
    ) i_dut (
        .clk     ( clk     ),
        .clk_32k ( clk_32k ),
        .arst_n  ( arst_n  ),
        .apb_req ( apb_req ),
        .apb_rsp ( apb_rsp ),
        .irq_src ( irq_src ),
        .msip    ( msip    ),
        .mtip    ( mtip    ),
        .meip    ( meip    )
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // slow time base shortened from a real 32 kHz period
    initial begin
        clk_32k = 1'b0;
        forever #85 clk_32k = ~clk_32k;
    end

    initial begin
        #200_000;
        $display("watchdog expired at %0t ns before the table was finished", $time);
        $display("Test FAILED");
        $finish;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // highest priority above thr and the lowest id within a level
    function automatic int top_source(input logic [NUM_SRC-1:0] pend, input int thr);
        for (int p = (1 << PRIO_W) - 1; p > thr; p--) begin
            for (int i = 0; i < NUM_SRC; i++) begin
                if (pend[i] && (prio_m[i] == prio_t'(p))) begin
                    return i + 1;
                end
            end
        end
        return 0;
    endfunction

    function automatic logic pin_value(input int pin);
        case (pin)
            PIN_MEIP: return meip;
            PIN_MTIP: return mtip;
            default:  return msip;
        endcase
    endfunction

    function automatic void add_row(input op_e op, input paddr_t offset, input pdata_t data,
                                    input pdata_t expected);
        row_t r;
        r.op       = op;
        r.offset   = offset;
        r.data     = data;
        r.expected = expected;
        table_q.push_back(r);
    endfunction

    task automatic check_value(input val_t actual, input val_t expected, input string what);
        checks++;
        if (actual !== expected) begin
            mismatches++;
            $display("mismatch at %0t ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic apb_xfer(input logic is_write, input paddr_t addr, input pdata_t wd,
                            output pdata_t rd, output logic err);
        int n;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.paddr   = addr;
        apb_req.pwrite  = is_write;
        apb_req.pstrb   = '1;
        apb_req.pwdata  = wd;
        @(negedge clk);
        apb_req.penable = 1'b1;
        n = 0;
        // sample late in the access cycle before the rising edge
        #4;
        while (!apb_rsp.pready && n < APB_TIMEOUT) begin
            @(negedge clk);
            #4;
            n++;
        end
        if (!apb_rsp.pready) begin
            timeouts++;
            $display("timeout at %0t ns: no pready for the transfer at offset %0h", $time, addr);
        end
        rd  = apb_rsp.prdata;
        err = apb_rsp.pslverr;
        @(negedge clk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic apb_write(input paddr_t addr, input pdata_t wd, output logic err);
        pdata_t rd_ignored;
        apb_xfer(1'b1, addr, wd, rd_ignored, err);
    endtask

    task automatic apb_read(input paddr_t addr, output pdata_t rd, output logic err);
        apb_xfer(1'b0, addr, '0, rd, err);
    endtask

    task automatic wait_level(input int pin, input logic level, input int limit);
        int   n;
        logic now;
        n   = 0;
        now = pin_value(pin);
        while (now !== level && n < limit) begin
            @(negedge clk);
            n++;
            now = pin_value(pin);
        end
        if (now !== level) begin
            timeouts++;
            $display("timeout at %0t ns: %s did not reach %0b within %0d cycles",
                     $time, pin_names[pin], level, limit);
        end
    endtask

    // read the system time after some slow clock periods
    task automatic check_time(input int ticks, input logic must_advance);
        pdata_t   lo;
        pdata_t   hi;
        logic     err;
        systime_t now_t;
        for (int t = 0; t < ticks; t++) begin
            @(posedge clk_32k);
        end
        @(negedge clk);
        apb_read(REG_MTIME_LO, lo, err);
        check_value(val_t'(err), 64'd0, "pslverr on mtime low read");
        apb_read(REG_MTIME_HI, hi, err);
        check_value(val_t'(err), 64'd0, "pslverr on mtime high read");
        now_t = {hi, lo};
        // the first read only sets the reference point
        if (time_seen) begin
            check_value(val_t'(now_t >= last_time), 64'd1, "mtime at or above previous read");
            if (must_advance) begin
                check_value(val_t'(now_t > last_time), 64'd1, "mtime advanced");
            end
        end
        last_time = now_t;
        time_seen = 1'b1;
    endtask

    task automatic run_row(input row_t r);
        pdata_t rd;
        logic   err;
        case (r.op)
            OP_WR: begin
                apb_write(r.offset, r.data, err);
                check_value(val_t'(err), val_t'(r.expected),
                            $sformatf("pslverr on write to %0h", r.offset));
            end
            OP_RD: begin
                apb_read(r.offset, rd, err);
                check_value(val_t'(err), 64'd0, $sformatf("pslverr on read of %0h", r.offset));
                check_value(val_t'(rd), val_t'(r.expected), $sformatf("read of %0h", r.offset));
            end
            OP_RDERR: begin
                apb_read(r.offset, rd, err);
                check_value(val_t'(err), 64'd1, $sformatf("pslverr on read of %0h", r.offset));
            end
            OP_IRQ: begin
                irq_src = r.data[NUM_SRC-1:0];
                @(negedge clk);
            end
            OP_PIN:  wait_level(int'(r.offset), r.expected[0], int'(r.data));
            OP_TIME: check_time(int'(r.data), r.expected[0]);
        endcase
    endtask

    task automatic build_table();
        int                 id;
        prio_t              p;
        logic               any_prio;
        logic [NUM_SRC-1:0] pend_m;
        logic [NUM_SRC-1:0] claimed;
        // reset state
        add_row(OP_PIN, PIN_MEIP, 1, 0);
        add_row(OP_PIN, PIN_MTIP, 1, 0);
        add_row(OP_PIN, PIN_MSIP, 1, 0);
        add_row(OP_RD, REG_PENDING, 0, 0);
        add_row(OP_RD, REG_CLAIM, 0, 0);
        add_row(OP_RD, REG_MTIMECMP_HI, 0, 32'hFFFF_FFFF);
        add_row(OP_RDERR, 32'h0000_0300, 0, 0);
        add_row(OP_WR, REG_PENDING, 0, 1);
        add_row(OP_WR, REG_MTIME_LO, 0, 1);
        // system time, compare and software interrupt
        add_row(OP_TIME, 0, 0, 0);
        add_row(OP_TIME, 0, 20, 1);
        add_row(OP_TIME, 0, 2, 0);
        add_row(OP_WR, REG_MTIMECMP_LO, 0, 0);
        add_row(OP_WR, REG_MTIMECMP_HI, 0, 0);
        add_row(OP_PIN, PIN_MTIP, 5, 1);
        add_row(OP_WR, REG_MTIMECMP_HI, 32'hFFFF_FFFF, 0);
        add_row(OP_WR, REG_MTIMECMP_LO, 32'hFFFF_FFFF, 0);
        add_row(OP_PIN, PIN_MTIP, 5, 0);
        add_row(OP_WR, REG_MSIP, 1, 0);
        add_row(OP_PIN, PIN_MSIP, 2, 1);
        add_row(OP_RD, REG_MSIP, 0, 1);
        add_row(OP_WR, REG_MSIP, 0, 0);
        add_row(OP_PIN, PIN_MSIP, 2, 0);
        // random priorities, all enabled, all lines up
        any_prio = 1'b0;
        for (int i = 0; i < NUM_SRC; i++) begin
            p = '0;
            for (int b = 0; b < PRIO_W; b++) begin
                p    = {p[PRIO_W-2:0], lfsr[0]};
                lfsr = lfsr_step(lfsr);
            end
            prio_m[i] = p;
            any_prio  = any_prio | (p != '0);
            add_row(OP_WR, REG_PRIO_BASE + paddr_t'(4 * i), pdata_t'(p), 0);
            add_row(OP_RD, REG_PRIO_BASE + paddr_t'(4 * i), 0, pdata_t'(p));
        end
        add_row(OP_WR, REG_ENABLE, ALL_SRC, 0);
        add_row(OP_IRQ, 0, ALL_SRC, 0);
        add_row(OP_PIN, PIN_MEIP, 5, pdata_t'(any_prio));
        add_row(OP_RD, REG_PENDING, 0, ALL_SRC);
        pend_m  = '1;
        claimed = '0;
        id      = top_source(pend_m, 0);
        while (id != 0) begin
            add_row(OP_RD, REG_CLAIM, 0, pdata_t'(id));
            pend_m[id-1]  = 1'b0;
            claimed[id-1] = 1'b1;
            add_row(OP_RD, REG_PENDING, 0, pdata_t'(pend_m));
            id = top_source(pend_m, 0);
        end
        add_row(OP_RD, REG_CLAIM, 0, 0);
        add_row(OP_PIN, PIN_MEIP, 5, 0);
        // lines still high, so every completed source comes back
        for (int i = 0; i < NUM_SRC; i++) begin
            if (claimed[i]) begin
                add_row(OP_WR, REG_CLAIM, pdata_t'(i + 1), 0);
            end
        end
        add_row(OP_RD, REG_PENDING, 0, ALL_SRC);
        // masking by enable, zero priority and threshold
        add_row(OP_WR, REG_ENABLE, 0, 0);
        add_row(OP_WR, REG_THRESHOLD, 4, 0);
        add_row(OP_WR, REG_PRIO_BASE, 4, 0);
        add_row(OP_WR, REG_PRIO_BASE + 32'h4, 0, 0);
        add_row(OP_WR, REG_PRIO_BASE + 32'h8, 6, 0);
        add_row(OP_WR, REG_ENABLE, 32'h3, 0);
        add_row(OP_RD, REG_CLAIM, 0, 0);
        add_row(OP_PIN, PIN_MEIP, 1, 0);
        add_row(OP_WR, REG_THRESHOLD, 3, 0);
        add_row(OP_PIN, PIN_MEIP, 5, 1);
        add_row(OP_RD, REG_CLAIM, 0, 1);
        // line 1 dropped before its complete stays quiet
        add_row(OP_IRQ, 0, 32'h6, 0);
        add_row(OP_WR, REG_CLAIM, 1, 0);
        add_row(OP_RD, REG_PENDING, 0, 32'h6);
        add_row(OP_PIN, PIN_MEIP, 5, 0);
        add_row(OP_RD, REG_CLAIM, 0, 0);
        add_row(OP_WR, REG_ENABLE, 32'h7, 0);
        add_row(OP_PIN, PIN_MEIP, 5, 1);
        add_row(OP_RD, REG_CLAIM, 0, 3);
        add_row(OP_IRQ, 0, 0, 0);
        add_row(OP_WR, REG_CLAIM, 3, 0);
        add_row(OP_RD, REG_PENDING, 0, 32'h2);
        add_row(OP_PIN, PIN_MEIP, 5, 0);
        add_row(OP_RD, REG_CLAIM, 0, 0);
    endtask

    initial begin
        apb_req   = '0;
        irq_src   = '0;
        arst_n    = 1'b0;
        last_time = '0;
        time_seen = 1'b0;
        lfsr      = LFSR_SEED;
        build_table();
        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        foreach (table_q[k]) begin
            run_row(table_q[k]);
        end
        $display("%0d checks, %0d mismatches, %0d timeouts", checks, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* cpu_irq_subsys.f */
irq_pkg.sv
irq_gateway.sv
irq_claim_arb.sv
clint_timer.sv
irq_apb_regs.sv
cpu_irq_subsys.sv
cpu_irq_subsys_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cpu_irq_subsys_tb
FILELIST  ?= cpu_irq_subsys.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/100ps

.PHONY: sim clean

# pass or fail comes from the log, not from the simulator exit code
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Test OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
